// File: l1_dcache.f
verilog/l1_dcache_pkg.sv
verilog/dcache_data_way.sv
verilog/dcache_write_path.sv
verilog/dcache_tag_store.sv
verilog/dcache_read_stage.sv
verilog/l1_dcache.sv
sim/l1_dcache_properties.sv
sim/tb_l1_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the L1 data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_l1_dcache \
	-Mdir obj_dir \
	-f l1_dcache.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_l1_dcache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "Simulation passed" "$LOG"; then
	exit 0
fi
exit 1

// File: sim/l1_dcache_properties.sv
`default_nettype none

module l1_dcache_properties
	import l1_dcache_pkg::*;
(
	input wire logic            iCLOCK,
	input wire logic            inRESET,
	input wire logic            iRD_BUSY,
	input wire logic            iUP_REQ,
	input wire logic            oRD_VALID,
	input wire logic            oRD_HIT,
	input wire logic            oWR_BUSY,
	input wire logic [ways-1:0] way_we
);
	timeunit 1ns;
	timeprecision 1ps;

	a_way_we_onehot: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$onehot0(way_we)) else $error("More than one way written");		// One RAM per write

	a_hit_has_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		oRD_HIT |-> oRD_VALID) else $error("Hit without valid");

	a_stall_hides_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		iRD_BUSY |-> !oRD_VALID) else $error("Valid shown during stall");

	a_wr_busy_level: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		oWR_BUSY == iUP_REQ) else $error("Fill busy differs from upload request");

endmodule

bind l1_dcache l1_dcache_properties i_props (
	.iCLOCK    (iCLOCK),
	.inRESET   (inRESET),
	.iRD_BUSY  (iRD_BUSY),
	.iUP_REQ   (iUP_REQ),
	.oRD_VALID (oRD_VALID),
	.oRD_HIT   (oRD_HIT),
	.oWR_BUSY  (oWR_BUSY),
	.way_we    (way_we)
);

`default_nettype wire

// File: sim/tb_l1_dcache.sv
`default_nettype none

module tb_l1_dcache
	import l1_dcache_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int k_fill = 0;
	localparam int k_read = 1;
	localparam int k_upload = 2;
	localparam int k_remove = 3;

	logic iCLOCK = 1'b0;
	logic inRESET, iREMOVE, iRD_REQ, iRD_BUSY, iUP_REQ, iWR_REQ;
	logic oRD_BUSY, oRD_VALID, oRD_HIT, oUP_BUSY, oWR_BUSY;
	logic [addr_w-1:0] iRD_ADDR, iUP_ADDR, iWR_ADDR;
	logic [word_w-1:0] oRD_DATA, iUP_DATA;
	logic [3:0] iUP_MASK;
	logic [line_w-1:0] iWR_DATA;

	logic [tag_w-1:0]  m_tag  [ways][sets];	// Reference tags
	logic [stat_w-1:0] m_stat [ways][sets];	// Reference recency
	logic [line_w-1:0] m_data [ways][sets];	// Reference lines
	int step_kind[$];						// Stimulus table columns
	logic [31:0] step_addr[$];
	logic [3:0] step_mask[$];
	logic [31:0] step_data[$];
	logic step_hit[$];						// Expected hit of a read

	l1_dcache i_dut (.*);

	always #50 iCLOCK = ~iCLOCK;			// 100 ns period

	function automatic logic [31:0] make_addr(input logic [21:0] tag, input int set,
		input int word);
		return {tag, 4'(set), 4'(word), 2'b00};
	endfunction

	function automatic logic [2:0] find_model_way(input logic [31:0] addr);
		logic [2:0] res;
		res = '0;
		for (int w = ways - 1; w >= 0; w--) begin
			if (m_stat[w][addr[9:6]] != 0 && m_tag[w][addr[9:6]] == addr[31:10]) begin
				res = {1'b1, 2'(w)};
			end
		end
		return res;
	endfunction

	task automatic check_value(input string name, input logic [511:0] got,
		input logic [511:0] exp);
		if (got !== exp) begin
			$display("FAIL time %0t %s got %0h expected %0h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic wait_read_valid();
		logic done;
		done = 1'b0;
		for (int n = 0; n < 20 && !done; n++) begin
			@(negedge iCLOCK);				// Outputs settled here
			if (oRD_VALID) done = 1'b1;
		end
		if (!done) begin
			$display("Timeout, no read result appeared");
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// Expected word with status aging on a hit
	task automatic predict_read(input logic [31:0] addr, output logic [31:0] word);
		logic [2:0] hw;
		hw = find_model_way(addr);
		word = hw[2] ? m_data[hw[1:0]][addr[9:6]][addr[5:2]*32 +: 32] : 32'd0;
		if (hw[2]) begin
			for (int w = 0; w < ways; w++) begin
				if (w == hw[1:0]) m_stat[w][addr[9:6]] = 2'd3;
				else if (m_stat[w][addr[9:6]] >= 2) m_stat[w][addr[9:6]]--;
			end
		end
	endtask

	task automatic apply_fill(input logic [31:0] addr, input logic [511:0] line);
		logic [2:0] hw;
		int v;
		hw = find_model_way(addr);
		v = 0;
		for (int w = 1; w < ways; w++) begin
			if (m_stat[w][addr[9:6]] < m_stat[v][addr[9:6]]) v = w;	// Invalid is lowest
		end
		if (hw[2]) v = hw[1:0];				// Present line refilled in place
		m_tag[v][addr[9:6]] = addr[31:10];
		m_stat[v][addr[9:6]] = 2'd3;
		m_data[v][addr[9:6]] = line;
	endtask

	task automatic read_and_check(input logic [31:0] addr, input logic exp_hit);
		logic [31:0] word;
		predict_read(addr, word);
		@(posedge iCLOCK);
		iRD_REQ <= 1'b1;
		iRD_ADDR <= addr;
		@(posedge iCLOCK);
		iRD_REQ <= 1'b0;
		wait_read_valid();
		check_value("oRD_HIT", oRD_HIT, exp_hit);
		check_value("oRD_DATA", oRD_DATA, word);
	endtask

	task automatic fill_line(input logic [31:0] addr);
		logic [511:0] line;
		for (int i = 0; i < 16; i++) line[i*32 +: 32] = $urandom;
		apply_fill(addr, line);
		@(posedge iCLOCK);
		iWR_REQ <= 1'b1;
		iWR_ADDR <= addr;
		iWR_DATA <= line;
		@(negedge iCLOCK);
		check_value("oUP_BUSY", oUP_BUSY, 1'b1);	// Fill holds off uploads
		check_value("oWR_BUSY", oWR_BUSY, 1'b0);
		@(posedge iCLOCK);
		iWR_REQ <= 1'b0;
	endtask

	task automatic upload_word(input logic [31:0] addr, input logic [3:0] mask,
		input logic [31:0] data);
		logic [2:0] hw;
		hw = find_model_way(addr);
		for (int b = 0; b < 4 && hw[2]; b++) begin
			if (mask[b]) m_data[hw[1:0]][addr[9:6]][addr[5:2]*32 + b*8 +: 8] = data[b*8 +: 8];
		end
		@(posedge iCLOCK);
		iUP_REQ <= 1'b1;
		iUP_ADDR <= addr;
		iUP_MASK <= mask;
		iUP_DATA <= data;
		@(negedge iCLOCK);
		check_value("oWR_BUSY", oWR_BUSY, 1'b1);	// Upload holds off fills
		check_value("oUP_BUSY", oUP_BUSY, 1'b0);
		@(posedge iCLOCK);
		iUP_REQ <= 1'b0;
	endtask

	task automatic remove_all();
		for (int w = 0; w < ways; w++) begin
			for (int s = 0; s < sets; s++) m_stat[w][s] = 2'd0;
		end
		@(posedge iCLOCK);
		iREMOVE <= 1'b1;
		@(posedge iCLOCK);
		iREMOVE <= 1'b0;
	endtask

	task automatic add_step(input int kind, input logic [31:0] addr, input logic [3:0] mask,
		input logic [31:0] data, input logic exp_hit);
		step_kind.push_back(kind);
		step_addr.push_back(addr);
		step_mask.push_back(mask);
		step_data.push_back(data);
		step_hit.push_back(exp_hit);
	endtask

	// Consumer stall holds the result, then collision busy
	task automatic stall_and_collide();
		logic [31:0] word;
		predict_read(make_addr(22'h101, 1, 7), word);
		@(posedge iCLOCK);
		iRD_REQ <= 1'b1;
		iRD_ADDR <= make_addr(22'h101, 1, 7);
		@(posedge iCLOCK);
		iRD_REQ <= 1'b0;
		iRD_BUSY <= 1'b1;
		iRD_ADDR <= make_addr(22'h102, 2, 3);	// Lookup moves on meanwhile
		repeat (3) begin
			@(negedge iCLOCK);
			check_value("oRD_VALID", oRD_VALID, 1'b0);
			check_value("oRD_BUSY", oRD_BUSY, 1'b1);
		end
		@(posedge iCLOCK);
		iRD_BUSY <= 1'b0;
		wait_read_valid();
		check_value("oRD_HIT", oRD_HIT, 1'b1);		// Line filled by the table
		check_value("oRD_DATA", oRD_DATA, word);
		apply_fill(make_addr(22'h3a9, 9, 0), {16{32'h5a5a_1234}});
		@(posedge iCLOCK);
		iRD_REQ <= 1'b1;
		iWR_REQ <= 1'b1;
		iRD_ADDR <= make_addr(22'h3a9, 9, 4);
		iWR_ADDR <= make_addr(22'h3a9, 9, 0);
		iWR_DATA <= {16{32'h5a5a_1234}};
		@(negedge iCLOCK);
		check_value("oRD_BUSY", oRD_BUSY, 1'b1);	// Same line address
		@(posedge iCLOCK);
		iRD_REQ <= 1'b0;
		iWR_REQ <= 1'b0;
		@(negedge iCLOCK);
		check_value("oRD_VALID", oRD_VALID, 1'b0);	// Collided read dropped
		read_and_check(make_addr(22'h3a9, 9, 4), 1'b1);
	endtask

	initial begin
		void'($urandom(32'hcec4_b156));
		for (int w = 0; w < ways; w++) begin
			for (int s = 0; s < sets; s++) m_stat[w][s] = 2'd0;
		end
		inRESET = 1'b0;
		{iREMOVE, iRD_REQ, iRD_BUSY, iUP_REQ, iWR_REQ} = '0;
		{iRD_ADDR, iUP_ADDR, iWR_ADDR, iUP_DATA, iUP_MASK} = '0;
		iWR_DATA = '0;
		for (int i = 0; i < 3; i++) begin
			add_step(k_read, make_addr(22'(i * 77), i, i), 4'h0, 0, 1'b0);
		end
		for (int i = 1; i <= 3; i++) begin
			add_step(k_fill, make_addr(22'(256 + i), i, 0), 4'h0, 0, 1'b0);
		end
		for (int i = 1; i <= 3; i++) begin
			for (int wd = 0; wd < 16; wd += 5) begin
				add_step(k_read, make_addr(22'(256 + i), i, wd), 4'h0, 0, 1'b1);
			end
		end
		add_step(k_upload, make_addr(22'h102, 2, 6), 4'b0101, 32'hdead_beef, 1'b0);	// Partial mask
		add_step(k_read, make_addr(22'h102, 2, 6), 4'h0, 0, 1'b1);
		add_step(k_read, make_addr(22'h102, 2, 7), 4'h0, 0, 1'b1);
		add_step(k_upload, make_addr(22'h2ff, 2, 6), 4'b1111, 32'h1111_2222, 1'b0);	// Absent line
		add_step(k_read, make_addr(22'h2ff, 2, 6), 4'h0, 0, 1'b0);
		for (int t = 0; t < 5; t++) begin						// Victim choice in set 5
			add_step(k_fill, make_addr(22'(512 + t), 5, 0), 4'h0, 0, 1'b0);
			if (t % 2 == 1) begin
				add_step(k_read, make_addr(22'd512, 5, 1), 4'h0, 0, 1'b1);	// Ages the others
			end
		end
		for (int t = 0; t < 5; t++) begin
			add_step(k_read, make_addr(22'(512 + t), 5, 2), 4'h0, 0, t != 1);	// Oldest is 513
		end
		add_step(k_remove, 0, 4'h0, 0, 1'b0);
		add_step(k_read, make_addr(22'h101, 1, 0), 4'h0, 0, 1'b0);
		add_step(k_read, make_addr(22'h204, 5, 2), 4'h0, 0, 1'b0);
		repeat (10) @(posedge iCLOCK);
		inRESET <= 1'b1;
		for (int i = 0; i < step_kind.size(); i++) begin
			case (step_kind[i])
				k_fill:   fill_line(step_addr[i]);
				k_read:   read_and_check(step_addr[i], step_hit[i]);
				k_upload: upload_word(step_addr[i], step_mask[i], step_data[i]);
				default:  remove_all();
			endcase
			if (i == 20) stall_and_collide();		// Lines of sets 1 and 2 present here
		end
		repeat (2) @(posedge iCLOCK);
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/dcache_data_way.sv
`default_nettype none

module dcache_data_way
	import l1_dcache_pkg::*;
(
	input  wire logic                  iCLOCK,
	input  wire logic                  we,			// Strobe for this way only
	input  wire logic [set_w-1:0]      wr_set,
	input  wire logic [line_bytes-1:0] byte_en,
	input  wire logic [line_w-1:0]     wr_line,
	input  wire logic [set_w-1:0]      rd_set,
	output logic      [line_w-1:0]     rd_line		// One cycle after rd_set
);

	logic [line_w-1:0] mem [sets];	// One line per set

	always_ff @(posedge iCLOCK) begin
		if (we) begin
			for (int b = 0; b < line_bytes; b++) begin
				if (byte_en[b]) begin
					mem[wr_set][b*8 +: 8] <= wr_line[b*8 +: 8];	// Byte lane
				end
			end
		end
		rd_line <= mem[rd_set];		// Old data on same-edge write
	end

endmodule

`default_nettype wire

// File: verilog/dcache_read_stage.sv
`default_nettype none

module dcache_read_stage
	import l1_dcache_pkg::*;
(
	input  wire logic              iCLOCK,
	input  wire logic              inRESET,
	input  wire logic              iREMOVE,
	input  wire logic              iRD_REQ,
	input  wire logic              iRD_BUSY,
	input  wire logic              iWR_REQ,
	input  wire logic [addr_w-1:0] rd_addr,
	input  wire logic [addr_w-1:0] wr_addr,
	input  wire logic              rd_hit,
	input  wire logic [way_w-1:0]  rd_way,
	input  wire logic [line_w-1:0] way_line [ways],	// Registered RAM outputs
	output logic                   oRD_BUSY,
	output logic                   oRD_VALID,
	output logic                   oRD_HIT,
	output logic      [word_w-1:0] oRD_DATA
);

	logic                  collide;			// Fill to the line being read
	logic                  rd_valid_q;
	logic                  rd_hit_q;
	logic                  held_q;			// Word parked while consumer stalls
	logic [way_w-1:0]      rd_way_q;
	logic [word_sel_w-1:0] rd_word_q;
	logic [word_w-1:0]     hold_word;
	logic [line_w-1:0]     sel_line;
	logic [word_w-1:0]     sel_word;

	assign collide  = iRD_REQ && iWR_REQ
		&& rd_addr[addr_w-1:set_lsb] == wr_addr[addr_w-1:set_lsb];
	assign oRD_BUSY = iRD_BUSY || collide;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rd_valid_q <= 1'b0;
			rd_hit_q   <= 1'b0;
			held_q     <= 1'b0;
		end else if (iREMOVE) begin
			rd_valid_q <= 1'b0;		// Drop buffered result
			held_q     <= 1'b0;
		end else if (iRD_BUSY) begin
			held_q <= 1'b1;			// RAM output moves on, keep copy
		end else begin
			rd_valid_q <= iRD_REQ && !collide;
			rd_hit_q   <= rd_hit;
			held_q     <= 1'b0;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!iRD_BUSY) begin
			rd_way_q  <= rd_way;
			rd_word_q <= rd_addr[set_lsb-1:word_lsb];
		end else if (!held_q) begin
			hold_word <= sel_word;	// First stalled edge
		end
	end

	assign sel_line = way_line[rd_way_q];
	assign sel_word = sel_line[rd_word_q*word_w +: word_w];

	// Flags hidden while stalled, data kept
	assign oRD_VALID = rd_valid_q && !iRD_BUSY;
	assign oRD_HIT   = oRD_VALID && rd_hit_q;
	assign oRD_DATA  = (rd_valid_q && rd_hit_q) ? (held_q ? hold_word : sel_word) : '0;

endmodule

`default_nettype wire

// File: verilog/dcache_tag_store.sv
`default_nettype none

module dcache_tag_store
	import l1_dcache_pkg::*;
(
	input  wire logic              iCLOCK,
	input  wire logic              inRESET,
	input  wire logic              iREMOVE,
	input  wire logic              iRD_REQ,
	input  wire logic              iRD_BUSY,
	input  wire logic [addr_w-1:0] rd_addr,
	input  wire logic              iUP_REQ,
	input  wire logic [addr_w-1:0] up_addr,
	input  wire logic              iWR_REQ,
	input  wire logic [addr_w-1:0] wr_addr,
	output cache_op_e              op,
	output logic                   rd_hit,
	output logic      [way_w-1:0]  rd_way,
	output logic      [way_w-1:0]  up_way,
	output logic      [way_w-1:0]  fill_way
);

	logic [tag_w-1:0]  tag_q  [ways][sets];	// Address tags
	logic [stat_w-1:0] stat_q [ways][sets];	// Recency, 0 is invalid

	logic [tag_w-1:0]  rd_tag, up_tag, wr_tag;
	logic [set_w-1:0]  rd_set, up_set, wr_set;
	logic              up_hit;
	logic              fill_hit;			// Line already present
	logic [stat_w-1:0] min_stat;
	logic [way_w-1:0]  min_way;				// Oldest way in fill set

	assign rd_tag = rd_addr[addr_w-1:tag_lsb];
	assign rd_set = rd_addr[tag_lsb-1:set_lsb];
	assign up_tag = up_addr[addr_w-1:tag_lsb];
	assign up_set = up_addr[tag_lsb-1:set_lsb];
	assign wr_tag = wr_addr[addr_w-1:tag_lsb];
	assign wr_set = wr_addr[tag_lsb-1:set_lsb];

	// Valid tag match in one set, lowest way wins
	function automatic logic [way_w:0] lookup(input logic [tag_w-1:0] tag,
		input logic [set_w-1:0] set);
		logic [way_w:0] res;
		res = '0;
		for (int w = ways - 1; w >= 0; w--) begin
			if (stat_q[w][set] != stat_invalid && tag_q[w][set] == tag) begin
				res = {1'b1, way_w'(w)};
			end
		end
		return res;
	endfunction

	always_comb begin
		{rd_hit, rd_way} = lookup(rd_tag, rd_set);
		{up_hit, up_way} = lookup(up_tag, up_set);	// Each way's own status
	end

	// Victim for a fill
	always_comb begin
		{fill_hit, fill_way} = lookup(wr_tag, wr_set);	// Refill in place
		min_stat = stat_q[0][wr_set];
		min_way  = '0;
		for (int w = 1; w < ways; w++) begin
			if (stat_q[w][wr_set] < min_stat) begin		// Strict, low index keeps ties
				min_stat = stat_q[w][wr_set];
				min_way  = way_w'(w);
			end
		end
		if (!fill_hit) begin
			fill_way = min_way;		// Invalid ways have the lowest status
		end
	end

	// Priority upload, fill, read hit
	always_comb begin
		if (iUP_REQ) begin
			op = up_hit ? op_upload : op_idle;	// Miss also holds off a fill
			if (!up_hit && iRD_REQ && rd_hit && !iRD_BUSY) begin
				op = op_read_hit;
			end
		end else if (iWR_REQ) begin
			op = op_fill;
		end else if (iRD_REQ && rd_hit && !iRD_BUSY) begin
			op = op_read_hit;
		end else begin
			op = op_idle;
		end
	end

	always_ff @(posedge iCLOCK) begin
		case (op)
			op_fill:   tag_q[fill_way][wr_set] <= wr_tag;
			op_upload: tag_q[up_way][up_set]   <= up_tag;	// Same tag, upload set
			default: ;
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < ways; w++) begin
				for (int s = 0; s < sets; s++) begin
					stat_q[w][s] <= stat_invalid;
				end
			end
		end else if (iREMOVE) begin
			for (int w = 0; w < ways; w++) begin
				for (int s = 0; s < sets; s++) begin
					stat_q[w][s] <= stat_invalid;	// Flush all in one cycle
				end
			end
		end else begin
			case (op)
				op_fill: stat_q[fill_way][wr_set] <= stat_newest;
				op_read_hit: begin
					for (int w = 0; w < ways; w++) begin
						if (way_w'(w) == rd_way) begin
							stat_q[w][rd_set] <= stat_newest;
						end else if (stat_q[w][rd_set] > stat_w'(1)) begin
							stat_q[w][rd_set] <= stat_q[w][rd_set] - stat_w'(1);	// Age, never to 0
						end
					end
				end
				default: ;				// Upload keeps status
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/dcache_write_path.sv
`default_nettype none

module dcache_write_path
	import l1_dcache_pkg::*;
(
	input  wire cache_op_e               op,
	input  wire logic [way_w-1:0]        up_way,
	input  wire logic [way_w-1:0]        fill_way,
	input  wire logic                    iUP_REQ,
	input  wire logic                    iWR_REQ,
	input  wire logic [addr_w-1:0]       up_addr,
	input  wire logic [word_w/8-1:0]     up_mask,
	input  wire logic [word_w-1:0]       up_data,
	input  wire logic [addr_w-1:0]       wr_addr,
	input  wire logic [line_w-1:0]       wr_line,
	output logic                         oWR_BUSY,
	output logic                         oUP_BUSY,
	output logic      [ways-1:0]         way_we,
	output logic      [set_w-1:0]        wr_set,
	output logic      [line_bytes-1:0]   wr_byte_en,
	output logic      [line_w-1:0]       wr_line_out
);

	logic                  is_up;		// Upload owns the RAM port
	logic [word_sel_w-1:0] up_word;		// Word slot inside the line

	assign is_up   = (op == op_upload);
	assign up_word = up_addr[set_lsb-1:word_lsb];

	// Upload blocks fill and the other way round
	assign oWR_BUSY = iUP_REQ;
	assign oUP_BUSY = iWR_REQ;

	assign wr_set = is_up ? up_addr[tag_lsb-1:set_lsb] : wr_addr[tag_lsb-1:set_lsb];

	// Four byte enables moved to the word slot
	assign wr_byte_en = is_up ? (line_bytes'(up_mask) << (up_word * (word_w / 8)))
		: {line_bytes{1'b1}};

	// Word copied to every slot, enables pick one
	assign wr_line_out = is_up ? {(line_w / word_w){up_data}} : wr_line;

	always_comb begin
		for (int w = 0; w < ways; w++) begin
			way_we[w] = (is_up && up_way == way_w'(w))
				|| (op == op_fill && fill_way == way_w'(w));	// Only chosen way
		end
	end

endmodule

`default_nettype wire

// File: verilog/l1_dcache.sv
`default_nettype none

module l1_dcache
	import l1_dcache_pkg::*;
(
	input  wire logic              iCLOCK,
	input  wire logic              inRESET,
	input  wire logic              iREMOVE,		// Invalidate everything
	// Read lookup
	input  wire logic              iRD_REQ,
	output logic                   oRD_BUSY,
	input  wire logic [addr_w-1:0] iRD_ADDR,
	output logic                   oRD_VALID,
	output logic                   oRD_HIT,
	output logic      [word_w-1:0] oRD_DATA,
	input  wire logic              iRD_BUSY,		// Consumer stall
	// Masked word write to a present line
	input  wire logic              iUP_REQ,
	output logic                   oUP_BUSY,
	input  wire logic [word_w/8-1:0] iUP_MASK,
	input  wire logic [addr_w-1:0] iUP_ADDR,
	input  wire logic [word_w-1:0] iUP_DATA,
	// Line fill
	input  wire logic              iWR_REQ,
	output logic                   oWR_BUSY,
	input  wire logic [addr_w-1:0] iWR_ADDR,
	input  wire logic [line_w-1:0] iWR_DATA
);

	cache_op_e             op;				// This cycle's operation
	logic                  rd_hit;
	logic [way_w-1:0]      rd_way;
	logic [way_w-1:0]      up_way;
	logic [way_w-1:0]      fill_way;
	logic [ways-1:0]       way_we;			// One-hot or zero
	logic [set_w-1:0]      wr_set;
	logic [line_bytes-1:0] wr_byte_en;
	logic [line_w-1:0]     wr_line;
	logic [line_w-1:0]     way_line [ways];

	dcache_tag_store u_tag_store (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.iREMOVE  (iREMOVE),
		.iRD_REQ  (iRD_REQ),
		.iRD_BUSY (iRD_BUSY),
		.rd_addr  (iRD_ADDR),
		.iUP_REQ  (iUP_REQ),
		.up_addr  (iUP_ADDR),
		.iWR_REQ  (iWR_REQ),
		.wr_addr  (iWR_ADDR),
		.op       (op),
		.rd_hit   (rd_hit),
		.rd_way   (rd_way),
		.up_way   (up_way),
		.fill_way (fill_way)
	);

	dcache_write_path u_write_path (
		.op          (op),
		.up_way      (up_way),
		.fill_way    (fill_way),
		.iUP_REQ     (iUP_REQ),
		.iWR_REQ     (iWR_REQ),
		.up_addr     (iUP_ADDR),
		.up_mask     (iUP_MASK),
		.up_data     (iUP_DATA),
		.wr_addr     (iWR_ADDR),
		.wr_line     (iWR_DATA),
		.oWR_BUSY    (oWR_BUSY),
		.oUP_BUSY    (oUP_BUSY),
		.way_we      (way_we),
		.wr_set      (wr_set),
		.wr_byte_en  (wr_byte_en),
		.wr_line_out (wr_line)
	);

	// One RAM per way, all read at the lookup set
	for (genvar w = 0; w < ways; w++) begin : g_way
		dcache_data_way u_data_way (
			.iCLOCK  (iCLOCK),
			.we      (way_we[w]),
			.wr_set  (wr_set),
			.byte_en (wr_byte_en),
			.wr_line (wr_line),
			.rd_set  (iRD_ADDR[tag_lsb-1:set_lsb]),
			.rd_line (way_line[w])
		);
	end

	dcache_read_stage u_read_stage (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.iREMOVE   (iREMOVE),
		.iRD_REQ   (iRD_REQ),
		.iRD_BUSY  (iRD_BUSY),
		.iWR_REQ   (iWR_REQ),
		.rd_addr   (iRD_ADDR),
		.wr_addr   (iWR_ADDR),
		.rd_hit    (rd_hit),
		.rd_way    (rd_way),
		.way_line  (way_line),
		.oRD_BUSY  (oRD_BUSY),
		.oRD_VALID (oRD_VALID),
		.oRD_HIT   (oRD_HIT),
		.oRD_DATA  (oRD_DATA)
	);

endmodule

`default_nettype wire

// File: verilog/l1_dcache_pkg.sv
`default_nettype none

package l1_dcache_pkg;

	// Address layout  tag | set | word | byte
	localparam int addr_w     = 32;		// Byte address
	localparam int tag_w      = 22;		// Tag field
	localparam int set_w      = 4;		// Set index field
	localparam int word_sel_w = 4;		// Word in line
	localparam int tag_lsb    = 10;		// Tag starts here
	localparam int set_lsb    = 6;		// Set starts here
	localparam int word_lsb   = 2;		// Word index starts here

	// Geometry
	localparam int ways       = 4;		// Associativity
	localparam int way_w      = 2;		// Way number width
	localparam int sets       = 16;		// Lines per way
	localparam int line_w     = 512;	// Line in bits
	localparam int line_bytes = 64;		// Line in bytes, one enable each
	localparam int word_w     = 32;		// CPU word

	// Recency status per line
	localparam int stat_w = 2;
	localparam logic [stat_w-1:0] stat_invalid = 2'd0;	// Empty line
	localparam logic [stat_w-1:0] stat_newest  = 2'd3;	// Just filled or hit

	// Operation taken by the tag store in a cycle
	typedef enum logic [1:0] {
		op_idle,		// Nothing written
		op_upload,		// Masked word into a present line
		op_fill,		// Whole line from below
		op_read_hit		// Recency update only
	} cache_op_e;

endpackage

`default_nettype wire
